//--- inst_queue.f
+incdir+.
iq_pkg.sv
line_aligner.sv
iq_ptr_ctrl.sv
iq_storage.sv
inst_queue.sv
tb_inst_queue.sv

//--- inst_queue.sv
`timescale 1ns/1ns

module inst_queue import iq_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    // icache side
    input  logic  icache_valid_i,
    input  pc_t   icache_pc_i,
    input  line_t icache_data_i,
    output logic  instq_full_o,

    // fetch side
    output logic  iq0_vld_o,
    output pc_t   iq0_pc_o,
    output inst_t iq0_inst_o,
    output logic  iq1_vld_o,
    output pc_t   iq1_pc_o,
    output inst_t iq1_inst_o,

    // backend control
    input  logic  stall_iq_i,
    input  logic  flush_iq_i
);

    inst_t   slot_inst [LINE_INSTS];
    pc_t     slot_pc [LINE_INSTS];
    wr_cnt_t wr_cnt;

    iq_ptr_t wptr;
    iq_ptr_t rptr;
    logic    wr_en;
    logic    pop;
    logic    pair_vld;

    // both heads must be present to pop
    assign pair_vld = iq0_vld_o && iq1_vld_o;

    line_aligner u_line_aligner (
        .line_pc_i   (icache_pc_i),
        .line_data_i (icache_data_i),
        .slot_inst_o (slot_inst),
        .slot_pc_o   (slot_pc),
        .wr_cnt_o    (wr_cnt)
    );

    iq_ptr_ctrl u_iq_ptr_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .line_valid_i (icache_valid_i),
        .wr_cnt_i     (wr_cnt),
        .pair_vld_i   (pair_vld),
        .stall_i      (stall_iq_i),
        .flush_i      (flush_iq_i),
        .wptr_o       (wptr),
        .rptr_o       (rptr),
        .wr_en_o      (wr_en),
        .pop_o        (pop),
        .full_o       (instq_full_o)
    );

    iq_storage u_iq_storage (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en_i      (wr_en),
        .wptr_i       (wptr),
        .wr_cnt_i     (wr_cnt),
        .slot_inst_i  (slot_inst),
        .slot_pc_i    (slot_pc),
        .pop_i        (pop),
        .rptr_i       (rptr),
        .flush_i      (flush_iq_i),
        .head0_vld_o  (iq0_vld_o),
        .head1_vld_o  (iq1_vld_o),
        .head0_pc_o   (iq0_pc_o),
        .head1_pc_o   (iq1_pc_o),
        .head0_inst_o (iq0_inst_o),
        .head1_inst_o (iq1_inst_o)
    );

endmodule

//--- iq_pkg.sv
package iq_pkg;

    // queue geometry
    localparam int IQ_DEPTH   = 32;
    localparam int IQ_PTR_W   = $clog2(IQ_DEPTH);
    localparam int IQ_CNT_W   = IQ_PTR_W + 1;

    // cache line and instruction geometry
    localparam int LINE_INSTS = 16;
    localparam int INST_W     = 32;
    localparam int PC_W       = 64;
    localparam int LINE_BITS  = LINE_INSTS * INST_W;
    localparam int OFS_W      = $clog2(LINE_INSTS);
    localparam int INST_BYTES = INST_W / 8;

    // fetch consumes two entries at a time
    localparam int READ_PAIR  = 2;

    typedef logic [INST_W-1:0]    inst_t;
    typedef logic [PC_W-1:0]      pc_t;
    typedef logic [LINE_BITS-1:0] line_t;

    typedef logic [IQ_PTR_W-1:0]  iq_ptr_t;

    // 0 to IQ_DEPTH, one bit wider than a pointer
    typedef logic [IQ_CNT_W-1:0]  iq_cnt_t;

    // 1 to LINE_INSTS instructions from one line
    typedef logic [OFS_W:0]       wr_cnt_t;

endpackage

//--- iq_ptr_ctrl.sv
`timescale 1ns/1ns

module iq_ptr_ctrl import iq_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    line_valid_i,
    input  wr_cnt_t wr_cnt_i,
    input  logic    pair_vld_i,
    input  logic    stall_i,
    input  logic    flush_i,
    output iq_ptr_t wptr_o,
    output iq_ptr_t rptr_o,
    output logic    wr_en_o,
    output logic    pop_o,
    output logic    full_o
);

    iq_ptr_t wptr_q;
    iq_ptr_t rptr_q;
    iq_cnt_t cnt_q;
    iq_cnt_t cnt_d;
    iq_cnt_t cnt_add;
    iq_cnt_t cnt_sub;

    // fewer than one full line of free slots left
    assign full_o = cnt_q > iq_cnt_t'(IQ_DEPTH - LINE_INSTS);

    // flush wins over both write and pop
    assign wr_en_o = line_valid_i && !full_o && !flush_i;
    assign pop_o   = pair_vld_i && !stall_i && !flush_i;

    assign cnt_add = wr_en_o ? iq_cnt_t'(wr_cnt_i) : '0;
    assign cnt_sub = pop_o ? iq_cnt_t'(READ_PAIR) : '0;

    always_comb begin
        cnt_d = cnt_q + cnt_add - cnt_sub;
    end

    // pointers wrap naturally at IQ_DEPTH
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr_q <= '0;
        end else if (flush_i) begin
            wptr_q <= '0;
        end else if (wr_en_o) begin
            wptr_q <= wptr_q + iq_ptr_t'(wr_cnt_i);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rptr_q <= '0;
        end else if (flush_i) begin
            rptr_q <= '0;
        end else if (pop_o) begin
            rptr_q <= rptr_q + iq_ptr_t'(READ_PAIR);
        end
    end

    // occupancy, write and pop may land on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (flush_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    assign wptr_o = wptr_q;
    assign rptr_o = rptr_q;

endmodule

//--- iq_storage.sv
`timescale 1ns/1ns

module iq_storage import iq_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    wr_en_i,
    input  iq_ptr_t wptr_i,
    input  wr_cnt_t wr_cnt_i,
    input  inst_t   slot_inst_i [LINE_INSTS],
    input  pc_t     slot_pc_i [LINE_INSTS],
    input  logic    pop_i,
    input  iq_ptr_t rptr_i,
    input  logic    flush_i,
    output logic    head0_vld_o,
    output logic    head1_vld_o,
    output pc_t     head0_pc_o,
    output pc_t     head1_pc_o,
    output inst_t   head0_inst_o,
    output inst_t   head1_inst_o
);

    logic [IQ_DEPTH-1:0] valid_q;
    inst_t               inst_q [IQ_DEPTH];
    pc_t                 pc_q [IQ_DEPTH];

    logic [IQ_DEPTH-1:0] wr_mask;
    logic [IQ_DEPTH-1:0] pop_mask;
    iq_ptr_t             rptr_nxt;

    assign rptr_nxt = rptr_i + iq_ptr_t'(1);

    for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_entry
        iq_ptr_t         slot_idx;
        logic [OFS_W-1:0] slot_sel;

        // distance from the write pointer picks the source slot
        assign slot_idx = iq_ptr_t'(i) - wptr_i;
        assign slot_sel = slot_idx[OFS_W-1:0];

        assign wr_mask[i] = wr_en_i && (wr_cnt_t'(slot_idx) < wr_cnt_i);

        assign pop_mask[i] = pop_i &&
                             (iq_ptr_t'(i) == rptr_i || iq_ptr_t'(i) == rptr_nxt);

        always_ff @(posedge clk) begin
            if (wr_mask[i]) begin
                inst_q[i] <= slot_inst_i[slot_sel];
                pc_q[i]   <= slot_pc_i[slot_sel];
            end
        end
    end

    // a write never targets an entry being popped, occupancy keeps them apart
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q & ~pop_mask) | wr_mask;
        end
    end

    // oldest pair
    assign head0_vld_o  = valid_q[rptr_i];
    assign head0_pc_o   = pc_q[rptr_i];
    assign head0_inst_o = inst_q[rptr_i];

    assign head1_vld_o  = valid_q[rptr_nxt];
    assign head1_pc_o   = pc_q[rptr_nxt];
    assign head1_inst_o = inst_q[rptr_nxt];

endmodule

//--- line_aligner.sv
`timescale 1ns/1ns

module line_aligner import iq_pkg::*; (
    input  pc_t     line_pc_i,
    input  line_t   line_data_i,
    output inst_t   slot_inst_o [LINE_INSTS],
    output pc_t     slot_pc_o [LINE_INSTS],
    output wr_cnt_t wr_cnt_o
);

    logic [OFS_W-1:0]      ofs;
    line_t                 line_shift;
    logic [LINE_INSTS-1:0] slot_live;

    // word offset of the first wanted instruction inside the line
    assign ofs = line_pc_i[$clog2(INST_BYTES) +: OFS_W];

    // move the wanted word down to slot 0, zeros fill from the top
    assign line_shift = line_data_i >> (ofs * INST_W);

    // instructions from the offset to the end of the line
    assign wr_cnt_o = wr_cnt_t'(LINE_INSTS) - wr_cnt_t'(ofs);

    for (genvar k = 0; k < LINE_INSTS; k++) begin : g_slot
        assign slot_live[k] = wr_cnt_t'(k) < wr_cnt_o;

        // upper words are already zero after the shift
        assign slot_inst_o[k] = line_shift[k*INST_W +: INST_W];

        // pc steps by one instruction per slot
        assign slot_pc_o[k] = slot_live[k] ? line_pc_i + pc_t'(INST_BYTES * k) : '0;
    end

endmodule

//--- tb_iq_ref.svh
`ifndef TB_IQ_REF_SVH
`define TB_IQ_REF_SVH

// expected state of both heads and the back-pressure flag
typedef struct packed {
    logic  v0;
    logic  v1;
    logic  full;
    pc_t   pc0;
    pc_t   pc1;
    inst_t inst0;
    inst_t inst1;
} exp_t;

// oldest entry sits at index 0
pc_t   ref_pc_q[$];
inst_t ref_inst_q[$];

function automatic void clear_model();
    ref_pc_q.delete();
    ref_inst_q.delete();
endfunction

function automatic logic model_full();
    return ref_pc_q.size() > (IQ_DEPTH - LINE_INSTS);
endfunction

// one rising edge with flush first, then pop of the old pair and then the new line
function automatic void advance_model(input logic valid, input pc_t pc, input line_t data,
                                      input logic stall, input logic flush);
    logic do_pop;
    logic do_push;
    int   ofs;
    if (flush) begin
        clear_model();
        return;
    end
    do_pop  = (ref_pc_q.size() >= READ_PAIR) && !stall;
    do_push = valid && !model_full();
    if (do_pop) begin
        repeat (READ_PAIR) begin
            void'(ref_pc_q.pop_front());
            void'(ref_inst_q.pop_front());
        end
    end
    if (do_push) begin
        // word offset is pc bits 5 to 2
        ofs = int'(pc[5:2]);
        for (int k = ofs; k < LINE_INSTS; k++) begin
            ref_pc_q.push_back(pc + pc_t'(4 * (k - ofs)));
            ref_inst_q.push_back(data[k*32 +: 32]);
        end
    end
endfunction

function automatic exp_t expected_heads();
    exp_t e;
    e = '0;
    e.full = model_full();
    if (ref_pc_q.size() >= 1) begin
        e.v0    = 1'b1;
        e.pc0   = ref_pc_q[0];
        e.inst0 = ref_inst_q[0];
    end
    if (ref_pc_q.size() >= 2) begin
        e.v1    = 1'b1;
        e.pc1   = ref_pc_q[1];
        e.inst1 = ref_inst_q[1];
    end
    return e;
endfunction

`endif

//--- tb_inst_queue.sv
`timescale 1ns/1ns

module tb_inst_queue import iq_pkg::*; ();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 4;
    localparam int RAND_LINES      = 120;
    localparam int CYCLES_PER_LINE = 40;
    localparam int DIRECTED_CYCLES = 400;
    localparam int DRAIN_LIMIT     = 64;
    localparam int RUN_CYCLES      = RESET_CYCLES + DIRECTED_CYCLES
                                     + RAND_LINES * CYCLES_PER_LINE;

    logic  clk;
    logic  rst_n;
    logic  icache_valid_i;
    pc_t   icache_pc_i;
    line_t icache_data_i;
    logic  instq_full_o;
    logic  iq0_vld_o;
    pc_t   iq0_pc_o;
    inst_t iq0_inst_o;
    logic  iq1_vld_o;
    pc_t   iq1_pc_o;
    inst_t iq1_inst_o;
    logic  stall_iq_i;
    logic  flush_iq_i;

    integer seed;
    int     errors;
    int     checks;
    logic   stall_rand;
    string  test_name;

    `include "tb_iq_ref.svh"

    inst_queue u_inst_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .icache_valid_i (icache_valid_i),
        .icache_pc_i    (icache_pc_i),
        .icache_data_i  (icache_data_i),
        .instq_full_o   (instq_full_o),
        .iq0_vld_o      (iq0_vld_o),
        .iq0_pc_o       (iq0_pc_o),
        .iq0_inst_o     (iq0_inst_o),
        .iq1_vld_o      (iq1_vld_o),
        .iq1_pc_o       (iq1_pc_o),
        .iq1_inst_o     (iq1_inst_o),
        .stall_iq_i     (stall_iq_i),
        .flush_iq_i     (flush_iq_i)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_val(input string sig, input logic [63:0] want, input logic [63:0] got);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("** Error [%s] %s: expected %h, actual %h", test_name, sig, want, got);
        end
    endtask

    // next edge and 1 ns of hold before new values
    task automatic step();
        @(posedge clk);
        #1;
        stall_iq_i = stall_rand ? (($random(seed) % 2) != 0) : 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    // line stays on the bus until an edge takes it
    task automatic send_line(input pc_t pc, input line_t data);
        logic taken;
        taken          = 1'b0;
        icache_valid_i = 1'b1;
        icache_pc_i    = pc;
        icache_data_i  = data;
        while (!taken) begin
            #2;
            taken = !instq_full_o && !flush_iq_i;
            step();
        end
        icache_valid_i = 1'b0;
    endtask

    task automatic drain(input int max_cycles);
        int n;
        n          = 0;
        stall_rand = 1'b0;
        stall_iq_i = 1'b0;
        while (iq0_vld_o && iq1_vld_o && n < max_cycles) begin
            step();
            n++;
        end
        checks++;
        assert (!(iq0_vld_o && iq1_vld_o)) else begin
            errors++;
            $display("[%s] queue did not drain within %0d cycles", test_name, max_cycles);
        end
    endtask

    task automatic check_ptrs();
        check_val("wptr", '0, u_inst_queue.wptr);
        check_val("rptr", '0, u_inst_queue.rptr);
    endtask

    function automatic line_t make_line(input inst_t base);
        line_t l;
        for (int k = 0; k < LINE_INSTS; k++) begin
            l[k*INST_W +: INST_W] = base + inst_t'(k);
        end
        return l;
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int k = 0; k < LINE_INSTS; k++) begin
            l[k*INST_W +: INST_W] = $random(seed);
        end
        return l;
    endfunction

    function automatic pc_t rand_pc();
        pc_t pc;
        pc = {$random(seed), $random(seed)};
        pc[1:0] = 2'b00;
        return pc;
    endfunction

    // checks just before each edge and then advances the model by that edge
    initial begin : compare
        exp_t want;
        forever begin
            @(posedge clk);
            #3;
            if (!rst_n) begin
                clear_model();
            end
            want = expected_heads();
            check_val("iq0_vld", want.v0, iq0_vld_o);
            check_val("iq1_vld", want.v1, iq1_vld_o);
            check_val("instq_full", want.full, instq_full_o);
            if (want.v0) begin
                check_val("iq0_pc", want.pc0, iq0_pc_o);
                check_val("iq0_inst", want.inst0, iq0_inst_o);
            end
            if (want.v1) begin
                check_val("iq1_pc", want.pc1, iq1_pc_o);
                check_val("iq1_inst", want.inst1, iq1_inst_o);
            end
            if (rst_n) begin
                advance_model(icache_valid_i, icache_pc_i, icache_data_i, stall_iq_i,
                              flush_iq_i);
            end
        end
    end

    initial begin : watchdog
        #(RUN_CYCLES * CLK_PERIOD + 100);
        $display("timeout: run did not finish within %0d cycles", RUN_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : stimulus
        seed           = 32'hc66d1f88;
        errors         = 0;
        checks         = 0;
        stall_rand     = 1'b0;
        test_name      = "reset";
        rst_n          = 1'b0;
        icache_valid_i = 1'b0;
        icache_pc_i    = '0;
        icache_data_i  = '0;
        stall_iq_i     = 1'b0;
        flush_iq_i     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(2);

        test_name = "aligned_line";
        send_line(64'h0000_0000_8000_0000, make_line(32'h1000_0000));
        drain(DRAIN_LIMIT);
        idle(3);

        // 3 entries and the last one waits alone in iq0
        test_name = "offset_13";
        send_line(64'h0000_0000_8000_0074, make_line(32'h2000_0000));
        drain(DRAIN_LIMIT);
        idle(4);
        send_line(64'h0000_0000_8000_0080, make_line(32'h3000_0000));
        drain(DRAIN_LIMIT);
        idle(3);

        test_name  = "random_traffic";
        stall_rand = 1'b1;
        for (int i = 0; i < RAND_LINES; i++) begin
            send_line(rand_pc(), rand_line());
        end
        drain(DRAIN_LIMIT);
        idle(3);

        test_name  = "flush_idle";
        stall_rand = 1'b1;
        repeat (3) send_line(rand_pc(), rand_line());
        flush_iq_i = 1'b1;
        step();
        flush_iq_i = 1'b0;
        check_ptrs();
        idle(2);

        // line and flush on the same edge drop the line
        test_name = "flush_with_line";
        send_line(rand_pc(), rand_line());
        icache_valid_i = 1'b1;
        icache_pc_i    = rand_pc();
        icache_data_i  = rand_line();
        flush_iq_i     = 1'b1;
        step();
        icache_valid_i = 1'b0;
        flush_iq_i     = 1'b0;
        check_ptrs();
        idle(2);

        test_name  = "after_flush";
        stall_rand = 1'b0;
        send_line(64'h0000_0000_9000_0008, make_line(32'h4000_0000));
        drain(DRAIN_LIMIT);
        idle(3);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
